//--- src/pkt_buf_settings.svh
`ifndef PKT_BUF_SETTINGS_SVH
`define PKT_BUF_SETTINGS_SVH

// Word geometry
`define PKT_BUF_DATA_BYTES 8
`define PKT_BUF_WORDS      64

// Byte limits for a packet that is kept
`define PKT_BUF_MIN_SIZE   16
`define PKT_BUF_MAX_SIZE   256

// Per-packet sideband
`define PKT_BUF_META_BITS  16

// Descriptor queue entries
`define PKT_BUF_DESC_DEPTH 8

`endif

//--- src/pkt_buf_pkg.sv
`default_nettype none

`include "pkt_buf_settings.svh"

package pkt_buf_pkg;

    localparam int ADDR_BITS = $clog2(`PKT_BUF_WORDS);

    typedef logic [`PKT_BUF_DATA_BYTES*8-1:0]       data_t;
    typedef logic [ADDR_BITS-1:0]                   addr_t;
    // Address with a wrap bit on top, for occupancy math
    typedef logic [ADDR_BITS:0]                     ptr_t;
    typedef logic [15:0]                            size_t;
    typedef logic [$clog2(`PKT_BUF_DATA_BYTES)-1:0] mty_t;
    typedef logic [`PKT_BUF_META_BITS-1:0]          meta_t;

    // One entry per kept packet
    typedef struct packed {
        addr_t start;
        size_t size;
        meta_t meta;
        logic  err;
    } pkt_desc_t;

endpackage

`default_nettype wire

//--- src/pkt_buffer_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_buf_settings.svh"

module pkt_buffer_mem (
    input  wire logic               clk,
    // Write port
    input  wire logic               mem_wr_en,
    input  wire pkt_buf_pkg::addr_t mem_wr_addr,
    input  wire pkt_buf_pkg::data_t mem_wr_data,
    // Read port
    input  wire logic               mem_rd_en,
    input  wire pkt_buf_pkg::addr_t mem_rd_addr,
    output pkt_buf_pkg::data_t      mem_rd_data
);

    pkt_buf_pkg::data_t mem [`PKT_BUF_WORDS];

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[mem_wr_addr] <= mem_wr_data;
        end
    end

    // Registered read, holds its value while mem_rd_en is low
    always_ff @(posedge clk) begin
        if (mem_rd_en) begin
            mem_rd_data <= mem[mem_rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- src/desc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_buf_settings.svh"

module desc_fifo (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   desc_push,
    input  wire pkt_buf_pkg::pkt_desc_t desc_in,
    input  wire logic                   desc_pop,
    output pkt_buf_pkg::pkt_desc_t      desc_out,
    output logic                        desc_full,
    output logic                        desc_empty
);

    localparam int DEPTH    = `PKT_BUF_DESC_DEPTH;
    localparam int IDX_BITS = $clog2(DEPTH);

    pkt_buf_pkg::pkt_desc_t store [DEPTH];
    logic [IDX_BITS:0]      wr_ptr;
    logic [IDX_BITS:0]      rd_ptr;

    always_ff @(posedge clk) begin
        if (desc_push) begin
            store[wr_ptr[IDX_BITS-1:0]] <= desc_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (desc_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (desc_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head entry is visible without a read cycle
    assign desc_out   = store[rd_ptr[IDX_BITS-1:0]];
    assign desc_empty = (wr_ptr == rd_ptr);
    assign desc_full  = (wr_ptr[IDX_BITS] != rd_ptr[IDX_BITS]) &&
                        (wr_ptr[IDX_BITS-1:0] == rd_ptr[IDX_BITS-1:0]);

    // Enqueue drops instead of pushing into a full queue
    assert property (@(posedge clk) disable iff (!arst_n) desc_push |-> !desc_full)
        else $error("desc_fifo: push while full");

    // Dequeue only pops a waiting descriptor
    assert property (@(posedge clk) disable iff (!arst_n) desc_pop |-> !desc_empty)
        else $error("desc_fifo: pop while empty");

endmodule

`default_nettype wire

//--- src/packet_enqueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_buf_settings.svh"

module packet_enqueue #(
    parameter bit DROP_ERRORED = 1'b1
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    // Input stream, no back-pressure
    input  wire logic               in_valid,
    input  wire pkt_buf_pkg::data_t in_data,
    input  wire logic               in_eop,
    input  wire pkt_buf_pkg::mty_t  in_mty,
    input  wire logic               in_err,
    input  wire pkt_buf_pkg::meta_t in_meta,
    // Read side state
    input  wire pkt_buf_pkg::ptr_t  head_ptr,
    input  wire logic               desc_full,
    // Memory write port
    output logic                    mem_wr_en,
    output pkt_buf_pkg::addr_t      mem_wr_addr,
    output pkt_buf_pkg::data_t      mem_wr_data,
    // Descriptor push and drop pulse
    output logic                    desc_push,
    output pkt_buf_pkg::pkt_desc_t  desc_in,
    output logic                    drop
);

    localparam int BYTE_SHIFT = $clog2(`PKT_BUF_DATA_BYTES);
    localparam int SIZE_BITS  = $bits(pkt_buf_pkg::size_t);
    localparam int CNT_BITS   = SIZE_BITS - BYTE_SHIFT;
    localparam int WIDE_BITS  = SIZE_BITS + 1;
    localparam int ADDR_BITS  = $bits(pkt_buf_pkg::addr_t);

    localparam pkt_buf_pkg::ptr_t BUF_WORDS = pkt_buf_pkg::ptr_t'(`PKT_BUF_WORDS);

    // ==================================================
    // Pointers and per-packet state
    // ==================================================
    pkt_buf_pkg::ptr_t    wr_ptr;
    pkt_buf_pkg::ptr_t    tail_ptr;
    pkt_buf_pkg::ptr_t    used_words;
    logic [CNT_BITS-1:0]  word_cnt;
    logic                 ovf;

    logic                 word_fits;
    logic [WIDE_BITS-1:0] pkt_bytes;
    logic                 size_ok;
    logic                 err_drop;
    logic                 keep;

    // Words held by unread packets plus the packet in flight
    assign used_words = wr_ptr - head_ptr;

    // Once a word is lost the rest of the packet is discarded too
    assign word_fits = !ovf && (used_words != BUF_WORDS);

    assign mem_wr_en   = in_valid && word_fits;
    assign mem_wr_addr = wr_ptr[ADDR_BITS-1:0];
    assign mem_wr_data = in_data;

    // ==================================================
    // Commit or drop at the last word
    // ==================================================
    // Earlier beats count as full words, this beat loses in_mty bytes.
    // The extra bit keeps a saturated count from wrapping.
    assign pkt_bytes = (WIDE_BITS'(word_cnt) << BYTE_SHIFT)
                     + WIDE_BITS'(`PKT_BUF_DATA_BYTES)
                     - WIDE_BITS'(in_mty);

    assign size_ok = (pkt_bytes >= WIDE_BITS'(`PKT_BUF_MIN_SIZE)) &&
                     (pkt_bytes <= WIDE_BITS'(`PKT_BUF_MAX_SIZE));

    assign err_drop = DROP_ERRORED && in_err;

    // Kept packets span two or more words, so the previous push has
    // already landed in desc_full by the time this one is decided
    assign keep = word_fits && size_ok && !err_drop && !desc_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            tail_ptr  <= '0;
            word_cnt  <= '0;
            ovf       <= 1'b0;
            desc_push <= 1'b0;
            drop      <= 1'b0;
        end else begin
            desc_push <= 1'b0;
            drop      <= 1'b0;
            if (in_valid) begin
                if (in_eop) begin
                    word_cnt <= '0;
                    ovf      <= 1'b0;
                    if (keep) begin
                        wr_ptr    <= wr_ptr + 1'b1;
                        tail_ptr  <= wr_ptr + 1'b1;
                        desc_push <= 1'b1;
                    end else begin
                        // Give back every word of the dropped packet
                        wr_ptr <= tail_ptr;
                        drop   <= 1'b1;
                    end
                end else begin
                    if (word_cnt != '1) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (word_fits) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end else begin
                        ovf <= 1'b1;
                    end
                end
            end
        end
    end

    // Descriptor contents, qualified by desc_push
    always_ff @(posedge clk) begin
        if (in_valid && in_eop) begin
            desc_in.start <= tail_ptr[ADDR_BITS-1:0];
            desc_in.size  <= pkt_bytes[SIZE_BITS-1:0];
            desc_in.meta  <= in_meta;
            desc_in.err   <= in_err;
        end
    end

    // No write lands on a word that dequeue has not yet freed
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr_en |=> (pkt_buf_pkg::ptr_t'(wr_ptr - head_ptr) <= BUF_WORDS))
        else $error("packet_enqueue: write into a full buffer");

endmodule

`default_nettype wire

//--- src/packet_dequeue.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_buf_settings.svh"

module packet_dequeue (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    // Descriptor queue
    input  wire logic                   desc_empty,
    input  wire pkt_buf_pkg::pkt_desc_t desc_out,
    output logic                        desc_pop,
    // Memory read port
    output logic                        mem_rd_en,
    output pkt_buf_pkg::addr_t          mem_rd_addr,
    input  wire pkt_buf_pkg::data_t     mem_rd_data,
    // Output stream
    input  wire logic                   out_rdy,
    output logic                        out_valid,
    output pkt_buf_pkg::data_t          out_data,
    output logic                        out_eop,
    output pkt_buf_pkg::mty_t           out_mty,
    output logic                        out_err,
    output pkt_buf_pkg::meta_t          out_meta,
    // Freed space back to enqueue
    output pkt_buf_pkg::ptr_t           head_ptr
);

    localparam int BYTE_SHIFT = $clog2(`PKT_BUF_DATA_BYTES);

    localparam pkt_buf_pkg::size_t WORD_BYTES = pkt_buf_pkg::size_t'(`PKT_BUF_DATA_BYTES);

    // Current packet being read
    logic               cur_active;
    pkt_buf_pkg::addr_t rd_addr;
    pkt_buf_pkg::size_t rem_bytes;
    pkt_buf_pkg::ptr_t  cur_words;
    pkt_buf_pkg::meta_t cur_meta;
    logic               cur_err;

    pkt_buf_pkg::ptr_t  pop_words;
    pkt_buf_pkg::ptr_t  out_words;
    logic               out_free;
    logic               issue;
    logic               last_word;

    // Output slot empties this cycle or is already empty
    assign out_free  = !out_valid || out_rdy;
    assign issue     = cur_active && out_free;
    assign last_word = (rem_bytes <= WORD_BYTES);

    // Next descriptor is taken while its predecessor's last word is read
    assign desc_pop = !desc_empty && (!cur_active || (issue && last_word));

    assign pop_words = pkt_buf_pkg::ptr_t'((desc_out.size + (WORD_BYTES - 1'b1)) >> BYTE_SHIFT);

    assign mem_rd_en   = issue;
    assign mem_rd_addr = rd_addr;

    // Memory read register doubles as the output data register
    assign out_data = mem_rd_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_active <= 1'b0;
            out_valid  <= 1'b0;
            head_ptr   <= '0;
        end else begin
            if (desc_pop) begin
                cur_active <= 1'b1;
            end else if (issue && last_word) begin
                cur_active <= 1'b0;
            end
            if (out_free) begin
                out_valid <= issue;
            end
            if (out_valid && out_rdy && out_eop) begin
                head_ptr <= head_ptr + out_words;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (desc_pop) begin
            rd_addr   <= desc_out.start;
            rem_bytes <= desc_out.size;
            cur_words <= pop_words;
            cur_meta  <= desc_out.meta;
            cur_err   <= desc_out.err;
        end else if (issue) begin
            rd_addr   <= rd_addr + 1'b1;
            rem_bytes <= rem_bytes - WORD_BYTES;
        end
        // Sideband follows the word into the output slot
        if (issue) begin
            out_eop   <= last_word;
            out_mty   <= last_word ? pkt_buf_pkg::mty_t'(WORD_BYTES - rem_bytes) : '0;
            out_err   <= cur_err;
            out_meta  <= cur_meta;
            out_words <= cur_words;
        end
    end

    // A stalled word must not change, including the data held in the memory
    assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_rdy) |=> (out_valid && $stable(out_data) &&
                                     $stable(out_eop) && $stable(out_mty)))
        else $error("packet_dequeue: output changed under back-pressure");

endmodule

`default_nettype wire

//--- src/packet_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module packet_buffer #(
    parameter bit DROP_ERRORED = 1'b1
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    // Input stream
    input  wire logic               in_valid,
    input  wire pkt_buf_pkg::data_t in_data,
    input  wire logic               in_eop,
    input  wire pkt_buf_pkg::mty_t  in_mty,
    input  wire logic               in_err,
    input  wire pkt_buf_pkg::meta_t in_meta,
    // Output stream
    input  wire logic               out_rdy,
    output logic                    out_valid,
    output pkt_buf_pkg::data_t      out_data,
    output logic                    out_eop,
    output pkt_buf_pkg::mty_t       out_mty,
    output logic                    out_err,
    output pkt_buf_pkg::meta_t      out_meta,
    output logic                    drop
);

    // ==================================================
    // Internal connections
    // ==================================================
    logic                   mem_wr_en;
    pkt_buf_pkg::addr_t     mem_wr_addr;
    pkt_buf_pkg::data_t     mem_wr_data;
    logic                   mem_rd_en;
    pkt_buf_pkg::addr_t     mem_rd_addr;
    pkt_buf_pkg::data_t     mem_rd_data;
    pkt_buf_pkg::ptr_t      head_ptr;
    logic                   desc_push;
    logic                   desc_pop;
    logic                   desc_full;
    logic                   desc_empty;
    pkt_buf_pkg::pkt_desc_t desc_in;
    pkt_buf_pkg::pkt_desc_t desc_out;

    packet_enqueue #(
        .DROP_ERRORED (DROP_ERRORED)
    ) u_enqueue (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_eop      (in_eop),
        .in_mty      (in_mty),
        .in_err      (in_err),
        .in_meta     (in_meta),
        .head_ptr    (head_ptr),
        .desc_full   (desc_full),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .desc_push   (desc_push),
        .desc_in     (desc_in),
        .drop        (drop)
    );

    pkt_buffer_mem u_mem (
        .clk         (clk),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data)
    );

    desc_fifo u_desc_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .desc_push  (desc_push),
        .desc_in    (desc_in),
        .desc_pop   (desc_pop),
        .desc_out   (desc_out),
        .desc_full  (desc_full),
        .desc_empty (desc_empty)
    );

    packet_dequeue u_dequeue (
        .clk         (clk),
        .arst_n      (arst_n),
        .desc_empty  (desc_empty),
        .desc_out    (desc_out),
        .desc_pop    (desc_pop),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .out_rdy     (out_rdy),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_eop     (out_eop),
        .out_mty     (out_mty),
        .out_err     (out_err),
        .out_meta    (out_meta),
        .head_ptr    (head_ptr)
    );

endmodule

`default_nettype wire

//--- tb/packet_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_buf_settings.svh"

module packet_buffer_tb;

    localparam int WORD_BYTES = `PKT_BUF_DATA_BYTES;
    localparam int BUF_WORDS  = `PKT_BUF_WORDS;
    localparam int MIN_SIZE   = `PKT_BUF_MIN_SIZE;
    localparam int MAX_SIZE   = `PKT_BUF_MAX_SIZE;
    localparam int WAIT_LIMIT = 5000;

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    pkt_buf_pkg::data_t in_data;
    logic               in_eop;
    pkt_buf_pkg::mty_t  in_mty;
    logic               in_err;
    pkt_buf_pkg::meta_t in_meta;
    logic               out_rdy;
    logic               out_valid;
    pkt_buf_pkg::data_t out_data;
    logic               out_eop;
    pkt_buf_pkg::mty_t  out_mty;
    logic               out_err;
    pkt_buf_pkg::meta_t out_meta;
    logic               drop;

    // Reference queue and collected output
    pkt_buf_pkg::data_t exp_words [$];
    int                 exp_sizes [$];
    pkt_buf_pkg::meta_t exp_metas [$];
    pkt_buf_pkg::data_t got_words [$];
    int                 got_sizes [$];
    pkt_buf_pkg::meta_t got_metas [$];
    logic               got_errs  [$];

    logic [31:0] lfsr_state;
    logic        rdy_random;
    int          committed_words;
    int          freed_words;
    int          beat_cnt;
    int          exp_drops;
    int          drop_seen;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    packet_buffer #(
        .DROP_ERRORED (1'b1)
    ) DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_eop    (in_eop),
        .in_mty    (in_mty),
        .in_err    (in_err),
        .in_meta   (in_meta),
        .out_rdy   (out_rdy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_eop   (out_eop),
        .out_mty   (out_mty),
        .out_err   (out_err),
        .out_meta  (out_meta),
        .drop      (drop)
    );

    always #4 clk = ~clk;

    // ==================================================
    // Output monitor
    // ==================================================
    always @(posedge clk) begin
        if (arst_n && out_valid && out_rdy) begin
            got_words.push_back(out_data);
            beat_cnt++;
            if (out_eop) begin
                got_sizes.push_back(beat_cnt * WORD_BYTES - int'(out_mty));
                got_metas.push_back(out_meta);
                got_errs.push_back(out_err);
                // head_ptr moves by the same amount on this edge
                freed_words += beat_cnt;
                beat_cnt = 0;
            end
        end
        if (arst_n && drop) begin
            drop_seen++;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input string field,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("FAIL %s %s expected %0h actual %0h", name, field, expected, actual);
        error_count++;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        if (rdy_random) begin
            out_rdy = (take_bits(1) != 0);
        end
    endtask

    task automatic end_input();
        next_cycle();
        in_valid = 1'b0;
        in_eop   = 1'b0;
    endtask

    task automatic pick_length(input int min_words, output int nwords, output int mty);
        nwords = min_words + int'(take_bits(5)) % (33 - min_words);
        mty    = int'(take_bits(3));
        if (nwords * WORD_BYTES - mty < MIN_SIZE) begin
            mty = 0;
        end
    endtask

    // ==================================================
    // Packet driver with free-space model
    // ==================================================
    task automatic send_packet(input int nwords, input int mty, input logic err,
                               output logic kept);
        pkt_buf_pkg::data_t words [$];
        pkt_buf_pkg::data_t word;
        pkt_buf_pkg::meta_t meta;
        int                 written;
        int                 used;
        int                 size;
        int                 i;
        logic               fits;
        written = 0;
        fits    = 1'b1;
        meta    = pkt_buf_pkg::meta_t'(take_bits(16));
        size    = nwords * WORD_BYTES - mty;
        for (i = 0; i < nwords; i++) begin
            word = {take_bits(32), take_bits(32)};
            words.push_back(word);
            next_cycle();
            // Occupancy the DUT sees when it samples this beat
            used = committed_words + written - freed_words;
            if (fits && used < BUF_WORDS) begin
                written++;
            end else begin
                fits = 1'b0;
            end
            in_valid = 1'b1;
            in_data  = word;
            in_eop   = (i == nwords - 1);
            in_mty   = (i == nwords - 1) ? pkt_buf_pkg::mty_t'(mty) : '0;
            in_err   = err;
            in_meta  = meta;
        end
        kept = fits && !err && size >= MIN_SIZE && size <= MAX_SIZE;
        if (kept) begin
            committed_words += nwords;
            exp_sizes.push_back(size);
            exp_metas.push_back(meta);
            foreach (words[j]) begin
                exp_words.push_back(words[j]);
            end
        end else begin
            exp_drops++;
        end
    endtask

    task automatic compare_output(input string name);
        pkt_buf_pkg::data_t ew;
        pkt_buf_pkg::data_t gw;
        pkt_buf_pkg::meta_t em;
        pkt_buf_pkg::meta_t gm;
        logic               ge;
        int                 es;
        int                 gs;
        int                 nw_exp;
        int                 nw_got;
        int                 k;
        int                 waited;
        end_input();
        waited = 0;
        while ((got_sizes.size() < exp_sizes.size() || drop_seen < exp_drops) &&
               waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (waited == WAIT_LIMIT) begin
            $display("%s: timed out waiting for output packets or drop pulses", name);
            error_count++;
            exp_words.delete();
            exp_sizes.delete();
            exp_metas.delete();
            got_words.delete();
            got_sizes.delete();
            got_metas.delete();
            got_errs.delete();
            exp_drops = drop_seen;
            return;
        end
        if (drop_seen != exp_drops) begin
            report_mismatch(name, "drop count", 64'(exp_drops), 64'(drop_seen));
        end
        while (exp_sizes.size() > 0) begin
            es = exp_sizes.pop_front();
            gs = got_sizes.pop_front();
            em = exp_metas.pop_front();
            gm = got_metas.pop_front();
            ge = got_errs.pop_front();
            if (gs != es) begin
                report_mismatch(name, "size", 64'(es), 64'(gs));
            end
            if (gm !== em) begin
                report_mismatch(name, "meta", 64'(em), 64'(gm));
            end
            if (ge !== 1'b0) begin
                report_mismatch(name, "err", 64'(0), 64'(ge));
            end
            nw_exp = (es + WORD_BYTES - 1) / WORD_BYTES;
            nw_got = (gs + WORD_BYTES - 1) / WORD_BYTES;
            for (k = 0; k < nw_exp; k++) begin
                ew = exp_words.pop_front();
                if (k < nw_got) begin
                    gw = got_words.pop_front();
                    if (gw !== ew) begin
                        report_mismatch(name, "data word", ew, gw);
                    end
                end
            end
            for (k = nw_exp; k < nw_got; k++) begin
                gw = got_words.pop_front();
            end
        end
        if (got_sizes.size() != 0) begin
            $display("%s: %0d packets came out that should have been dropped",
                     name, got_sizes.size());
            error_count++;
            got_sizes.delete();
            got_metas.delete();
            got_errs.delete();
            got_words.delete();
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s passed", name);
        end else begin
            tests_failed++;
            $display("%s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic single_packet_test();
        int   errs0;
        int   nwords;
        int   mty;
        logic kept;
        errs0 = error_count;
        pick_length(2, nwords, mty);
        send_packet(nwords, mty, 1'b0, kept);
        compare_output("single_packet");
        finish_test("single_packet", errs0);
    endtask

    task automatic err_packet_test();
        int   errs0;
        int   nwords;
        int   mty;
        logic kept;
        errs0 = error_count;
        pick_length(2, nwords, mty);
        send_packet(nwords, mty, 1'b1, kept);
        pick_length(2, nwords, mty);
        send_packet(nwords, mty, 1'b0, kept);
        compare_output("err_packet");
        finish_test("err_packet", errs0);
    endtask

    task automatic size_limits_test();
        int   errs0;
        logic kept;
        errs0 = error_count;
        send_packet(2, 1, 1'b0, kept);
        send_packet(2, 0, 1'b0, kept);
        send_packet(33, 7, 1'b0, kept);
        send_packet(32, 0, 1'b0, kept);
        compare_output("size_limits");
        finish_test("size_limits", errs0);
    endtask

    task automatic overflow_test();
        int   errs0;
        int   drops0;
        int   i;
        logic kept;
        errs0   = error_count;
        out_rdy = 1'b0;
        // Four 16-word packets fill the buffer exactly
        for (i = 0; i < 5; i++) begin
            drops0 = drop_seen;
            send_packet(16, 0, 1'b0, kept);
            // Drop pulse lands one cycle after the last beat
            end_input();
            next_cycle();
            if ((drop_seen - drops0) != ((i == 4) ? 1 : 0)) begin
                report_mismatch("overflow", "drop pulses", 64'(i == 4),
                                64'(drop_seen - drops0));
            end
        end
        end_input();
        out_rdy = 1'b1;
        compare_output("overflow");
        send_packet(16, 0, 1'b0, kept);
        compare_output("overflow");
        finish_test("overflow", errs0);
    endtask

    task automatic burst_backpressure_test();
        int   errs0;
        int   i;
        int   nwords;
        int   mty;
        logic kept;
        errs0      = error_count;
        rdy_random = 1'b1;
        // At least 8 words each, so the buffer fills before the descriptor FIFO
        for (i = 0; i < 30; i++) begin
            pick_length(8, nwords, mty);
            send_packet(nwords, mty, 1'b0, kept);
        end
        compare_output("burst_backpressure");
        rdy_random = 1'b0;
        out_rdy    = 1'b1;
        finish_test("burst_backpressure", errs0);
    endtask

    initial begin
        clk             = 1'b0;
        arst_n          = 1'b0;
        in_valid        = 1'b0;
        in_data         = '0;
        in_eop          = 1'b0;
        in_mty          = '0;
        in_err          = 1'b0;
        in_meta         = '0;
        out_rdy         = 1'b1;
        rdy_random      = 1'b0;
        lfsr_state      = 32'h8cc8;
        committed_words = 0;
        freed_words     = 0;
        beat_cnt        = 0;
        exp_drops       = 0;
        drop_seen       = 0;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        if (out_valid !== 1'b0) begin
            report_mismatch("reset", "out_valid", 64'(0), 64'(out_valid));
        end
        if (drop !== 1'b0) begin
            report_mismatch("reset", "drop", 64'(0), 64'(drop));
        end
        single_packet_test();
        err_packet_test();
        size_limits_test();
        overflow_test();
        burst_backpressure_test();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/pkt_buf_pkg.sv
src/pkt_buffer_mem.sv
src/desc_fifo.sv
src/packet_enqueue.sv
src/packet_dequeue.sv
src/packet_buffer.sv
tb/packet_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the packet buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module packet_buffer_tb --Mdir obj_dir -o packet_buffer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/packet_buffer_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
